// ==== i2c_master_config.svh ====
// Build-time settings; the FIFO depth must equal 2**I2C_FIFO_PTR_W and quarter cycles fit 8 bits
`ifndef I2C_MASTER_CONFIG_SVH
`define I2C_MASTER_CONFIG_SVH

// System clocks per quarter of an SCL bit period
`define I2C_QUARTER_CYCLES 5

// Command FIFO geometry
`define I2C_FIFO_DEPTH 8
`define I2C_FIFO_PTR_W 3

// Value of rd_data before the first read completes
`define I2C_RD_DATA_RESET 8'h00

// Drive-low enable level that leaves a bus line released
`define I2C_BUS_RELEASE 1'b0

`endif

// ==== i2c_bus_pkg.sv ====
// Bus timing types; a bit is four quarters, SCL low in Q0 and Q3 and high in Q1 and Q2
package i2c_bus_pkg;

   // Phase within one SCL bit
   typedef enum logic [1:0]
   {
      Q0,
      Q1,
      Q2,
      Q3
   } quarter_t;

   // Byte engine FSM
   typedef enum logic [2:0]
   {
      ENG_IDLE,
      ENG_START,
      ENG_STOP,
      ENG_BITS,
      ENG_ACK
   } engine_state_t;

   typedef logic [3:0] bit_count_t;
   typedef logic [7:0] div_count_t;

endpackage

// ==== i2c_cmd_pkg.sv ====
// Command word layout is opcode in bits 9:8 and byte in bits 7:0; START and STOP ignore the byte
package i2c_cmd_pkg;

   typedef logic [6:0] dev_addr_t;
   typedef logic [7:0] reg_addr_t;
   typedef logic [7:0] data_byte_t;

   typedef enum logic [1:0]
   {
      CMD_START,
      CMD_STOP,
      CMD_WRITE,
      CMD_READ
   } cmd_op_t;

   typedef logic [9:0] cmd_word_t;

   function automatic cmd_word_t make_cmd(cmd_op_t op, data_byte_t data);
      return {op, data};
   endfunction

   function automatic cmd_op_t cmd_op(cmd_word_t word);
      return cmd_op_t'(word[9:8]);
   endfunction

   function automatic data_byte_t cmd_byte(cmd_word_t word);
      return word[7:0];
   endfunction

endpackage

// ==== i2c_txn_sequencer.sv ====
// One transaction at a time; a NACK sets ack_error but the transfer still runs to its STOP
`include "i2c_master_config.svh"

module i2c_txn_sequencer
(
   input  logic                    sda,
   input  logic                    reset,
   input  logic                    start,
   input  logic                    rw,
   input  i2c_cmd_pkg::dev_addr_t  dev_addr,
   input  i2c_cmd_pkg::reg_addr_t  reg_addr,
   input  i2c_cmd_pkg::data_byte_t wr_data,
   input  logic                    full,
   input  logic                    byte_nack,
   input  logic                    rd_valid,
   input  i2c_cmd_pkg::data_byte_t rd_byte,
   input  logic                    stop_done,
   output logic                    push,
   output i2c_cmd_pkg::cmd_word_t  push_word,
   output logic                    busy,
   output logic                    done,
   output i2c_cmd_pkg::data_byte_t rd_data,
   output logic                    ack_error
);

   logic                    req_rw;
   i2c_cmd_pkg::dev_addr_t  req_dev;
   i2c_cmd_pkg::reg_addr_t  req_reg;
   i2c_cmd_pkg::data_byte_t req_data;
   i2c_bus_pkg::bit_count_t cmd_idx;
   i2c_bus_pkg::bit_count_t cmd_count;
   logic                    accept;

   assign accept = start && !busy;

   // Read adds a repeated START and the address byte with the read bit
   assign cmd_count = req_rw ? 4'd7 : 4'd5;

   assign push = busy && (cmd_idx < cmd_count) && !full;

   // Command list by position in the transaction
   always_comb
   begin
      case (cmd_idx)
         4'd0:    push_word = i2c_cmd_pkg::make_cmd(i2c_cmd_pkg::CMD_START, 8'h00);
         4'd1:    push_word = i2c_cmd_pkg::make_cmd(i2c_cmd_pkg::CMD_WRITE, {req_dev, 1'b0});
         4'd2:    push_word = i2c_cmd_pkg::make_cmd(i2c_cmd_pkg::CMD_WRITE, req_reg);
         4'd3:
         begin
            if (req_rw)
               push_word = i2c_cmd_pkg::make_cmd(i2c_cmd_pkg::CMD_START, 8'h00);
            else
               push_word = i2c_cmd_pkg::make_cmd(i2c_cmd_pkg::CMD_WRITE, req_data);
         end
         4'd4:
         begin
            if (req_rw)
               push_word = i2c_cmd_pkg::make_cmd(i2c_cmd_pkg::CMD_WRITE, {req_dev, 1'b1});
            else
               push_word = i2c_cmd_pkg::make_cmd(i2c_cmd_pkg::CMD_STOP, 8'h00);
         end
         4'd5:    push_word = i2c_cmd_pkg::make_cmd(i2c_cmd_pkg::CMD_READ, 8'hFF);
         default: push_word = i2c_cmd_pkg::make_cmd(i2c_cmd_pkg::CMD_STOP, 8'h00);
      endcase
   end

   always_ff @(posedge sda)
   begin
      if (reset)
      begin
         busy      <= 1'b0;
         done      <= 1'b0;
         ack_error <= 1'b0;
         rd_data   <= `I2C_RD_DATA_RESET;
         cmd_idx   <= '0;
      end
      else
      begin
         done <= 1'b0;
         if (accept)
         begin
            busy      <= 1'b1;
            ack_error <= 1'b0;
            cmd_idx   <= '0;
         end
         else if (busy)
         begin
            if (push)
               cmd_idx <= cmd_idx + 4'd1;
            // Sticky until the next accepted start
            if (byte_nack)
               ack_error <= 1'b1;
            if (rd_valid)
               rd_data <= rd_byte;
            // STOP is always the last command
            if (stop_done)
            begin
               busy <= 1'b0;
               done <= 1'b1;
            end
         end
      end
   end

   // Request fields held for the whole transaction
   always_ff @(posedge sda)
   begin
      if (accept)
      begin
         req_rw   <= rw;
         req_dev  <= dev_addr;
         req_reg  <= reg_addr;
         req_data <= wr_data;
      end
   end

   // The engine finishes a transaction only while one is open
   a_stop_in_txn: assert property (@(posedge sda) disable iff (reset)
      stop_done |-> busy && (cmd_idx == cmd_count));

endmodule

// ==== i2c_cmd_fifo.sv ====
// Depth must be a power of two; the caller must not push when full nor pop when empty
`include "i2c_master_config.svh"

module i2c_cmd_fifo
(
   input  logic                   sda,
   input  logic                   reset,
   input  logic                   push,
   input  i2c_cmd_pkg::cmd_word_t push_word,
   input  logic                   pop,
   output i2c_cmd_pkg::cmd_word_t pop_word,
   output logic                   full,
   output logic                   empty
);

   i2c_cmd_pkg::cmd_word_t     mem [`I2C_FIFO_DEPTH];
   logic [`I2C_FIFO_PTR_W-1:0] wr_ptr;
   logic [`I2C_FIFO_PTR_W-1:0] rd_ptr;
   logic [`I2C_FIFO_PTR_W-1:0] rd_ptr_next;
   i2c_bus_pkg::bit_count_t    count;

   assign full        = (count == i2c_bus_pkg::bit_count_t'(`I2C_FIFO_DEPTH));
   assign empty       = (count == '0);
   assign rd_ptr_next = pop ? rd_ptr + 1'b1 : rd_ptr;

   always_ff @(posedge sda)
   begin
      if (push)
         mem[wr_ptr] <= push_word;
   end

   // Registered head; a push into an empty slot is forwarded directly
   always_ff @(posedge sda)
   begin
      if (push && (wr_ptr == rd_ptr_next))
         pop_word <= push_word;
      else
         pop_word <= mem[rd_ptr_next];
   end

   always_ff @(posedge sda)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         rd_ptr <= rd_ptr_next;
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 4'd1;
            2'b01:   count <= count - 4'd1;
            default: count <= count;
         endcase
      end
   end

   a_no_pop_when_empty: assert property (@(posedge sda) disable iff (reset)
      pop |-> !empty);

   a_no_push_when_full: assert property (@(posedge sda) disable iff (reset)
      push |-> !full);

endmodule

// ==== i2c_byte_engine.sv ====
// Sole bus master, no clock stretching or arbitration; i2c_data_in must already be synchronous
`include "i2c_master_config.svh"

module i2c_byte_engine
(
   input  logic                    sda,
   input  logic                    reset,
   input  logic                    empty,
   input  i2c_cmd_pkg::cmd_word_t  pop_word,
   input  logic                    i2c_data_in,
   output logic                    pop,
   output logic                    i2c_clk_low,
   output logic                    i2c_data_low,
   output logic                    byte_nack,
   output logic                    rd_valid,
   output i2c_cmd_pkg::data_byte_t rd_byte,
   output logic                    stop_done
);

   i2c_bus_pkg::engine_state_t state;
   i2c_bus_pkg::quarter_t      quarter;
   i2c_bus_pkg::div_count_t    div_cnt;
   i2c_bus_pkg::bit_count_t    bit_cnt;
   i2c_cmd_pkg::data_byte_t    shift;
   logic                       is_read;
   logic                       ack_bit;
   logic                       qtick;
   logic                       scl_drive;
   logic                       sda_drive;

   assign qtick   = (div_cnt == i2c_bus_pkg::div_count_t'(`I2C_QUARTER_CYCLES - 1));
   assign pop     = (state == i2c_bus_pkg::ENG_IDLE) && !empty;
   assign rd_byte = shift;

   // Line pattern for the current state and quarter
   always_comb
   begin
      scl_drive = i2c_clk_low;
      sda_drive = i2c_data_low;
      case (state)
         i2c_bus_pkg::ENG_START:
         begin
            // Release SDA with SCL low, raise SCL, then pull SDA low
            scl_drive = (quarter == i2c_bus_pkg::Q0) || (quarter == i2c_bus_pkg::Q3);
            sda_drive = (quarter == i2c_bus_pkg::Q2) || (quarter == i2c_bus_pkg::Q3);
         end
         i2c_bus_pkg::ENG_STOP:
         begin
            // SDA held low until SCL is high, then released
            scl_drive = (quarter == i2c_bus_pkg::Q0);
            sda_drive = (quarter == i2c_bus_pkg::Q0) || (quarter == i2c_bus_pkg::Q1);
         end
         i2c_bus_pkg::ENG_BITS:
         begin
            scl_drive = (quarter == i2c_bus_pkg::Q0) || (quarter == i2c_bus_pkg::Q3);
            sda_drive = !is_read && !shift[7];
         end
         i2c_bus_pkg::ENG_ACK:
         begin
            // Released for the target's ACK, and as the master NACK on reads
            scl_drive = (quarter == i2c_bus_pkg::Q0) || (quarter == i2c_bus_pkg::Q3);
            sda_drive = 1'b0;
         end
         default:
         begin
            scl_drive = i2c_clk_low;
            sda_drive = i2c_data_low;
         end
      endcase
   end

   always_ff @(posedge sda)
   begin
      if (reset)
      begin
         state        <= i2c_bus_pkg::ENG_IDLE;
         quarter      <= i2c_bus_pkg::Q0;
         div_cnt      <= '0;
         bit_cnt      <= '0;
         is_read      <= 1'b0;
         i2c_clk_low  <= `I2C_BUS_RELEASE;
         i2c_data_low <= `I2C_BUS_RELEASE;
         byte_nack    <= 1'b0;
         rd_valid     <= 1'b0;
         stop_done    <= 1'b0;
      end
      else
      begin
         byte_nack <= 1'b0;
         rd_valid  <= 1'b0;
         stop_done <= 1'b0;
         // Lines hold their last level while idle
         if (state != i2c_bus_pkg::ENG_IDLE)
         begin
            i2c_clk_low  <= scl_drive;
            i2c_data_low <= sda_drive;
         end
         if (state == i2c_bus_pkg::ENG_IDLE)
         begin
            if (!empty)
            begin
               div_cnt <= '0;
               quarter <= i2c_bus_pkg::Q0;
               bit_cnt <= '0;
               // Payload of the popped command
               shift   <= i2c_cmd_pkg::cmd_byte(pop_word);
               is_read <= (i2c_cmd_pkg::cmd_op(pop_word) == i2c_cmd_pkg::CMD_READ);
               case (i2c_cmd_pkg::cmd_op(pop_word))
                  i2c_cmd_pkg::CMD_START: state <= i2c_bus_pkg::ENG_START;
                  i2c_cmd_pkg::CMD_STOP:  state <= i2c_bus_pkg::ENG_STOP;
                  default:                state <= i2c_bus_pkg::ENG_BITS;
               endcase
            end
         end
         else if (!qtick)
         begin
            div_cnt <= div_cnt + 8'd1;
         end
         else
         begin
            div_cnt <= '0;
            quarter <= i2c_bus_pkg::quarter_t'(quarter + 2'd1);
            case (state)
               i2c_bus_pkg::ENG_BITS:
               begin
                  // Sample at the end of SCL high
                  if (quarter == i2c_bus_pkg::Q2 && is_read)
                     shift <= {shift[6:0], i2c_data_in};
                  if (quarter == i2c_bus_pkg::Q3)
                  begin
                     if (!is_read)
                        shift <= {shift[6:0], 1'b0};
                     if (bit_cnt == 4'd7)
                        state <= i2c_bus_pkg::ENG_ACK;
                     else
                        bit_cnt <= bit_cnt + 4'd1;
                  end
               end
               i2c_bus_pkg::ENG_ACK:
               begin
                  if (quarter == i2c_bus_pkg::Q2)
                     ack_bit <= i2c_data_in;
                  if (quarter == i2c_bus_pkg::Q3)
                  begin
                     state <= i2c_bus_pkg::ENG_IDLE;
                     if (is_read)
                        rd_valid <= 1'b1;
                     else
                        byte_nack <= ack_bit;
                  end
               end
               i2c_bus_pkg::ENG_STOP:
               begin
                  if (quarter == i2c_bus_pkg::Q3)
                  begin
                     state     <= i2c_bus_pkg::ENG_IDLE;
                     stop_done <= 1'b1;
                  end
               end
               default:
               begin
                  if (quarter == i2c_bus_pkg::Q3)
                     state <= i2c_bus_pkg::ENG_IDLE;
               end
            endcase
         end
      end
   end

   // SDA moves only under a low SCL, except for START and STOP conditions
   a_sda_stable_scl_high: assert property (@(posedge sda) disable iff (reset)
      $changed(i2c_data_low) |-> i2c_clk_low || (state == i2c_bus_pkg::ENG_START)
                                 || (state == i2c_bus_pkg::ENG_STOP));

endmodule

// ==== i2c_master_top.sv ====
// Drive-low outputs are open-drain enables; the wired-AND and pull-ups live outside
module i2c_master_top
(
   input  logic                    sda,
   input  logic                    reset,
   input  logic                    start,
   input  logic                    rw,
   input  i2c_cmd_pkg::dev_addr_t  dev_addr,
   input  i2c_cmd_pkg::reg_addr_t  reg_addr,
   input  i2c_cmd_pkg::data_byte_t wr_data,
   input  logic                    i2c_data_in,
   output logic                    busy,
   output logic                    done,
   output i2c_cmd_pkg::data_byte_t rd_data,
   output logic                    ack_error,
   output logic                    i2c_clk_low,
   output logic                    i2c_data_low
);

   // Sequencer to FIFO
   logic                    push;
   i2c_cmd_pkg::cmd_word_t  push_word;
   logic                    full;

   // FIFO to engine
   logic                    pop;
   i2c_cmd_pkg::cmd_word_t  pop_word;
   logic                    empty;

   // Engine status back to the sequencer
   logic                    byte_nack;
   logic                    rd_valid;
   i2c_cmd_pkg::data_byte_t rd_byte;
   logic                    stop_done;

   i2c_txn_sequencer i2c_txn_sequencer_i
   (
      .sda       (sda),
      .reset     (reset),
      .start     (start),
      .rw        (rw),
      .dev_addr  (dev_addr),
      .reg_addr  (reg_addr),
      .wr_data   (wr_data),
      .full      (full),
      .byte_nack (byte_nack),
      .rd_valid  (rd_valid),
      .rd_byte   (rd_byte),
      .stop_done (stop_done),
      .push      (push),
      .push_word (push_word),
      .busy      (busy),
      .done      (done),
      .rd_data   (rd_data),
      .ack_error (ack_error)
   );

   i2c_cmd_fifo i2c_cmd_fifo_i
   (
      .sda       (sda),
      .reset     (reset),
      .push      (push),
      .push_word (push_word),
      .pop       (pop),
      .pop_word  (pop_word),
      .full      (full),
      .empty     (empty)
   );

   i2c_byte_engine i2c_byte_engine_i
   (
      .sda          (sda),
      .reset        (reset),
      .empty        (empty),
      .pop_word     (pop_word),
      .i2c_data_in  (i2c_data_in),
      .pop          (pop),
      .i2c_clk_low  (i2c_clk_low),
      .i2c_data_low (i2c_data_low),
      .byte_nack    (byte_nack),
      .rd_valid     (rd_valid),
      .rd_byte      (rd_byte),
      .stop_done    (stop_done)
   );

endmodule

// ==== tb_i2c_target_model.sv ====
// Simulation only; one fixed address, 16 registers by the low address nibble, no clock stretching
module tb_i2c_target_model
#(
   parameter i2c_cmd_pkg::dev_addr_t device_addr = 7'h50
)
(
   input  logic i2c_clk_low,
   input  logic i2c_data_low,
   output logic target_data_low
);
   timeunit 1ns;
   timeprecision 100ps;

   typedef enum logic [2:0]
   {
      T_IDLE,
      T_ADDR,
      T_REG,
      T_WDATA,
      T_RDATA
   } target_phase_t;

   i2c_cmd_pkg::data_byte_t regs [16];
   target_phase_t           phase       = T_IDLE;
   target_phase_t           next_phase  = T_IDLE;
   int                      bit_cnt     = 0;
   i2c_cmd_pkg::data_byte_t shift_in    = '0;
   i2c_cmd_pkg::data_byte_t tx_byte     = '0;
   logic [3:0]              reg_ptr     = '0;
   logic                    master_nack = 1'b0;
   logic                    drive_low   = 1'b0;
   logic                    prev_scl    = 1'b1;
   logic                    prev_sda    = 1'b1;
   logic                    scl;
   logic                    sda_line;

   // Resolved open-drain lines
   assign scl             = !i2c_clk_low;
   assign sda_line        = !(i2c_data_low || drive_low);
   assign target_data_low = drive_low;

   initial
   begin
      regs = '{default: '0};
   end

   task automatic load_read_byte();
      tx_byte   = regs[reg_ptr];
      drive_low = !tx_byte[7];
   endtask

   // Rising SCL, bits 0 to 7 are data and 8 is the ACK slot
   task automatic sample_bit();
      if (phase != T_IDLE)
      begin
         if (bit_cnt < 8)
            shift_in = {shift_in[6:0], sda_line};
         else if (phase == T_RDATA)
            master_nack = sda_line;
         bit_cnt = bit_cnt + 1;
      end
   endtask

   task automatic finish_byte();
      drive_low = 1'b0;
      case (phase)
         T_ADDR:
         begin
            if (shift_in[7:1] == device_addr)
            begin
               drive_low  = 1'b1;
               next_phase = shift_in[0] ? T_RDATA : T_REG;
            end
            else
               phase = T_IDLE;
         end
         T_REG:
         begin
            reg_ptr    = shift_in[3:0];
            drive_low  = 1'b1;
            next_phase = T_WDATA;
         end
         T_WDATA:
         begin
            regs[reg_ptr] = shift_in;
            reg_ptr       = reg_ptr + 4'd1;
            drive_low     = 1'b1;
            next_phase    = T_WDATA;
         end
         default:
            next_phase = T_RDATA;
      endcase
   endtask

   task automatic finish_ack_slot();
      drive_low = 1'b0;
      bit_cnt   = 0;
      shift_in  = '0;
      if (phase == T_RDATA)
      begin
         reg_ptr = reg_ptr + 4'd1;
         if (master_nack)
            phase = T_IDLE;
         else
            load_read_byte();
      end
      else
      begin
         phase = next_phase;
         if (phase == T_RDATA)
            load_read_byte();
      end
   endtask

   // Falling SCL, the only time the target moves SDA
   task automatic finish_bit();
      if (phase == T_IDLE)
         drive_low = 1'b0;
      else if (bit_cnt == 8)
         finish_byte();
      else if (bit_cnt == 9)
         finish_ack_slot();
      else if ((phase == T_RDATA) && (bit_cnt > 0))
      begin
         tx_byte   = {tx_byte[6:0], 1'b0};
         drive_low = !tx_byte[7];
      end
   endtask

   always @(posedge scl or negedge scl or posedge sda_line or negedge sda_line)
   begin
      if (scl && prev_scl && (sda_line != prev_sda))
      begin
         // SDA moving under a high SCL is START (falling) or STOP (rising)
         if (!sda_line)
         begin
            phase    = T_ADDR;
            bit_cnt  = 0;
            shift_in = '0;
         end
         else
            phase = T_IDLE;
         drive_low = 1'b0;
      end
      else if (scl && !prev_scl)
         sample_bit();
      else if (!scl && prev_scl)
         finish_bit();
      prev_scl = scl;
      prev_sda = sda_line;
   end

endmodule

// ==== tb_i2c_master.sv ====
// Simulation only; the target answers at 0x50 and the run stops at the first mismatch or timeout
module tb_i2c_master;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int timeout_cycles = 20000;
   localparam int quiet_cycles   = 2000;

   // One row of the stimulus table
   typedef struct packed
   {
      logic                    rw;
      i2c_cmd_pkg::dev_addr_t  dev_addr;
      i2c_cmd_pkg::reg_addr_t  reg_addr;
      i2c_cmd_pkg::data_byte_t wr_data;
      i2c_cmd_pkg::data_byte_t exp_rd_data;
      logic                    exp_ack_error;
   } txn_entry_t;

   logic                    sda;
   logic                    reset;
   logic                    start;
   logic                    rw;
   i2c_cmd_pkg::dev_addr_t  dev_addr;
   i2c_cmd_pkg::reg_addr_t  reg_addr;
   i2c_cmd_pkg::data_byte_t wr_data;
   logic                    i2c_data_in;
   logic                    busy;
   logic                    done;
   i2c_cmd_pkg::data_byte_t rd_data;
   logic                    ack_error;
   logic                    i2c_clk_low;
   logic                    i2c_data_low;
   logic                    target_data_low;

   txn_entry_t              txn_table [$];

   // Wired-AND of the two open-drain SDA drivers
   assign i2c_data_in = !(i2c_data_low || target_data_low);

   i2c_master_top i2c_master_top_i
   (
      .sda          (sda),
      .reset        (reset),
      .start        (start),
      .rw           (rw),
      .dev_addr     (dev_addr),
      .reg_addr     (reg_addr),
      .wr_data      (wr_data),
      .i2c_data_in  (i2c_data_in),
      .busy         (busy),
      .done         (done),
      .rd_data      (rd_data),
      .ack_error    (ack_error),
      .i2c_clk_low  (i2c_clk_low),
      .i2c_data_low (i2c_data_low)
   );

   tb_i2c_target_model target_model_i
   (
      .i2c_clk_low     (i2c_clk_low),
      .i2c_data_low    (i2c_data_low),
      .target_data_low (target_data_low)
   );

   initial
   begin
      sda = 1'b0;
      forever #2 sda = !sda;
   end

   function automatic txn_entry_t make_entry(input logic rw_bit,
                                             input i2c_cmd_pkg::dev_addr_t dev,
                                             input i2c_cmd_pkg::reg_addr_t register,
                                             input i2c_cmd_pkg::data_byte_t data,
                                             input i2c_cmd_pkg::data_byte_t exp_rd,
                                             input logic exp_err);
      txn_entry_t entry;
      entry.rw            = rw_bit;
      entry.dev_addr      = dev;
      entry.reg_addr      = register;
      entry.wr_data       = data;
      entry.exp_rd_data   = exp_rd;
      entry.exp_ack_error = exp_err;
      return entry;
   endfunction

   // rw, device, register, write data, expected read data, expected ack_error
   task automatic fill_table();
      txn_table.push_back(make_entry(1'b0, 7'h50, 8'h03, 8'hA5, 8'h00, 1'b0));
      txn_table.push_back(make_entry(1'b1, 7'h50, 8'h03, 8'h00, 8'hA5, 1'b0));
      txn_table.push_back(make_entry(1'b0, 7'h50, 8'h07, 8'h3C, 8'h00, 1'b0));
      txn_table.push_back(make_entry(1'b0, 7'h50, 8'h0C, 8'h81, 8'h00, 1'b0));
      txn_table.push_back(make_entry(1'b0, 7'h50, 8'h07, 8'h5E, 8'h00, 1'b0));
      txn_table.push_back(make_entry(1'b1, 7'h50, 8'h07, 8'h00, 8'h5E, 1'b0));
      txn_table.push_back(make_entry(1'b1, 7'h50, 8'h0C, 8'h00, 8'h81, 1'b0));
      // Never written
      txn_table.push_back(make_entry(1'b1, 7'h50, 8'h0A, 8'h00, 8'h00, 1'b0));
      // No target at 0x21
      txn_table.push_back(make_entry(1'b0, 7'h21, 8'h02, 8'h77, 8'h00, 1'b1));
      txn_table.push_back(make_entry(1'b1, 7'h50, 8'h03, 8'h00, 8'hA5, 1'b0));
      txn_table.push_back(make_entry(1'b1, 7'h50, 8'h02, 8'h00, 8'h00, 1'b0));
   endtask

   task automatic stop_on_failure();
      $display("Test FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_value(input int actual, input int expected, input string what);
      if (actual != expected)
      begin
         $display("CHECK FAILED at %0t ns: %s, got 0x%0h, expected 0x%0h",
                  $time, what, actual, expected);
         stop_on_failure();
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout: %s not seen within %0d clock cycles", what, timeout_cycles);
      stop_on_failure();
   endtask

   task automatic wait_for_busy(input string what);
      int waited;
      waited = 0;
      @(negedge sda);
      while (!busy)
      begin
         if (waited >= timeout_cycles)
            report_timeout(what);
         waited = waited + 1;
         @(negedge sda);
      end
   endtask

   task automatic wait_for_done(input string what);
      int waited;
      waited = 0;
      @(negedge sda);
      while (!done)
      begin
         if (waited >= timeout_cycles)
            report_timeout(what);
         waited = waited + 1;
         @(negedge sda);
      end
   endtask

   // One cycle start pulse with the request fields
   task automatic issue_request(input txn_entry_t entry);
      @(posedge sda);
      start    <= 1'b1;
      rw       <= entry.rw;
      dev_addr <= entry.dev_addr;
      reg_addr <= entry.reg_addr;
      wr_data  <= entry.wr_data;
      @(posedge sda);
      start    <= 1'b0;
   endtask

   task automatic run_txn(input txn_entry_t entry, input int idx);
      string tag;
      tag = $sformatf("entry %0d", idx);
      issue_request(entry);
      wait_for_done({"done of ", tag});
      check_value(int'(busy), 0, {tag, " busy together with done"});
      check_value(int'(ack_error), int'(entry.exp_ack_error), {tag, " ack_error"});
      if (entry.rw)
         check_value(int'(rd_data), int'(entry.exp_rd_data), {tag, " rd_data"});
      @(negedge sda);
      check_value(int'(done), 0, {tag, " done wider than one cycle"});
   endtask

   task automatic check_reset_state();
      check_value(int'(busy), 0, "busy after reset");
      check_value(int'(done), 0, "done after reset");
      check_value(int'(ack_error), 0, "ack_error after reset");
      check_value(int'(i2c_clk_low), 0, "i2c_clk_low after reset");
      check_value(int'(i2c_data_low), 0, "i2c_data_low after reset");
   endtask

   task automatic check_start_ignored_while_busy();
      txn_entry_t first;
      txn_entry_t ignored;
      int         late_activity;
      first         = make_entry(1'b0, 7'h50, 8'h05, 8'h11, 8'h00, 1'b0);
      ignored       = make_entry(1'b0, 7'h50, 8'h05, 8'h99, 8'h00, 1'b0);
      late_activity = 0;
      issue_request(first);
      wait_for_busy("busy after the first request");
      issue_request(ignored);
      wait_for_done("done of the first request");
      check_value(int'(ack_error), 0, "ack_error with a start during busy");
      // A second transaction would raise busy again in this window
      repeat (quiet_cycles)
      begin
         @(negedge sda);
         if (done || busy)
            late_activity = late_activity + 1;
      end
      check_value(late_activity, 0, "cycles of activity after the ignored start");
      check_value(int'(target_model_i.regs[4'd5]), 32'h11, "target register 0x05");
      run_txn(make_entry(1'b1, 7'h50, 8'h05, 8'h00, 8'h11, 1'b0), txn_table.size());
   endtask

   initial
   begin
      reset    = 1'b1;
      start    = 1'b0;
      rw       = 1'b0;
      dev_addr = '0;
      reg_addr = '0;
      wr_data  = '0;
      fill_table();
      repeat (2) @(posedge sda);
      reset <= 1'b0;
      @(negedge sda);
      check_reset_state();
      foreach (txn_table[i])
         run_txn(txn_table[i], i);
      check_start_ignored_while_busy();
      $display("Test OK");
      $finish;
   end

endmodule

// ==== filelist.f ====
+incdir+.
i2c_bus_pkg.sv
i2c_cmd_pkg.sv
i2c_txn_sequencer.sv
i2c_cmd_fifo.sv
i2c_byte_engine.sv
i2c_master_top.sv
tb_i2c_target_model.sv
tb_i2c_master.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timescale 1ns/100ps --top-module tb_i2c_master -f filelist.f
output=$(./obj_dir/Vtb_i2c_master 2>&1 || true)
echo "$output"
if echo "$output" | grep -qx "Test OK"
then
   exit 0
fi
exit 1
